// File: hw/lsu_pkg.sv
// Shared widths, operation codes and record types of the load/store unit.
// Every lsu module imports this package.
package lsu_pkg;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned TRANS_ID_BITS = 3;

  typedef logic [XLEN-1:0]          data_t;
  typedef logic [XLEN-1:0]          addr_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [11:0]              imm_t;

  // load and store operations, byte/half/word only
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // RISC-V mcause encodings
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    ST_ADDR_MISALIGNED = 4'd6
  } exc_cause_e;

  // --------------------
  // records
  // --------------------
  typedef struct packed {
    lsu_op_e   op;
    addr_t     operand_a;
    imm_t      imm;
    data_t     operand_b;
    trans_id_t trans_id;
  } lsu_req_t;

  // decoded operation as held in the issue queue
  typedef struct packed {
    logic      valid;
    addr_t     vaddr;
    data_t     wdata;
    be_t       be;
    lsu_op_e   op;
    trans_id_t trans_id;
    logic      misaligned;
  } lsu_ctrl_t;

  typedef struct packed {
    logic       valid;
    exc_cause_e cause;
    addr_t      tval;
  } exc_t;

  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    data_t     result;
    exc_t      ex;
  } lsu_result_t;

  // data memory port, request side
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

endpackage

// File: hw/lsu_agu.sv
// Address generation: effective address, byte enables, lane-aligned store
// data and misalignment flag for a request coming from the core.
`timescale 1ns/1ns

module lsu_agu (
  input  lsu_pkg::lsu_req_t  req_i,
  output lsu_pkg::lsu_ctrl_t ctrl_o
);
  import lsu_pkg::*;

  addr_t      vaddr;
  logic [1:0] offset;
  be_t        be_base;
  logic       misaligned;

  // base plus sign-extended 12-bit offset
  assign vaddr  = req_i.operand_a + {{(XLEN-12){req_i.imm[11]}}, req_i.imm};
  assign offset = vaddr[1:0];

  // --------------------
  // size decode
  // --------------------
  always_comb begin
    unique case (req_i.op)
      LB, LBU, SB: begin
        be_base    = 4'b0001;
        misaligned = 1'b0;
      end
      LH, LHU, SH: begin
        be_base    = 4'b0011;
        misaligned = vaddr[0];
      end
      default: begin
        be_base    = 4'b1111;
        misaligned = |vaddr[1:0];
      end
    endcase
  end

  always_comb begin
    ctrl_o.valid      = 1'b1;
    ctrl_o.vaddr      = vaddr;
    // store data moved into its byte lanes
    ctrl_o.wdata      = req_i.operand_b << {offset, 3'b000};
    ctrl_o.be         = be_base << offset;
    ctrl_o.op         = req_i.op;
    ctrl_o.trans_id   = req_i.trans_id;
    ctrl_o.misaligned = misaligned;
  end

endmodule

// File: hw/lsu_issue_ctrl.sv
// Two-entry issue queue between the core and the load/store units.
// The head is shown to both units; only the matching one sees its valid.
`timescale 1ns/1ns

module lsu_issue_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               valid_i,
  input  lsu_pkg::lsu_ctrl_t ctrl_i,
  output logic               ready_o,
  input  logic               pop_ld_i,
  input  logic               pop_st_i,
  output lsu_pkg::lsu_ctrl_t head_o,
  output logic               ld_valid_o,
  output logic               st_valid_o
);
  import lsu_pkg::*;

  lsu_ctrl_t  entry_q [2];
  logic       rd_ptr_q;
  logic       wr_ptr_q;
  logic [1:0] cnt_q;
  logic       empty;
  logic       push;
  logic       pop;
  logic       head_is_load;

  assign empty   = (cnt_q == 2'd0);
  assign ready_o = (cnt_q != 2'd2);
  assign push    = valid_i && ready_o;
  assign pop     = pop_ld_i || pop_st_i;

  // --------------------
  // head decode
  // --------------------
  always_comb begin
    head_o       = entry_q[rd_ptr_q];
    head_o.valid = !empty;
  end

  assign head_is_load = head_o.op inside {LB, LBU, LH, LHU, LW};

  // nothing is offered to the units while the queue is being flushed
  assign ld_valid_o = !empty && !flush_i && head_is_load;
  assign st_valid_o = !empty && !flush_i && !head_is_load;

  // --------------------
  // pointers and fill count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else if (flush_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= ctrl_i;
    end
  end

  // only one unit owns the head at a time
  pop_exclusive_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_ld_i && pop_st_i))
    else $error("load and store unit popped the queue together");

  pop_nonempty_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop |-> !empty)
    else $error("issue queue popped while empty");

endmodule

// File: hw/lsu_load_unit.sv
// Load unit. Waits out store hazards, issues one word read at a time on the
// load port and returns the extended result one cycle after rvalid.
`timescale 1ns/1ns

module lsu_load_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 valid_i,
  input  lsu_pkg::lsu_ctrl_t   ctrl_i,
  output logic                 pop_o,
  output lsu_pkg::addr_t       hazard_addr_o,
  input  logic                 hazard_i,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  lsu_pkg::mem_rsp_t    mem_rsp_i,
  output lsu_pkg::lsu_result_t result_o
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_HAZARD,
    WAIT_GNT,
    WAIT_DATA
  } ld_state_e;

  ld_state_e   state_q, state_d;
  lsu_ctrl_t   ld_q;
  lsu_result_t result_q, result_d;
  logic        take_exc;
  logic        take_load;

  function automatic data_t extract(lsu_op_e op, logic [1:0] off, data_t rdata);
    data_t sh;
    sh = rdata >> {off, 3'b000};
    case (op)
      LB:      return {{24{sh[7]}}, sh[7:0]};
      LBU:     return {24'b0, sh[7:0]};
      LH:      return {{16{sh[15]}}, sh[15:0]};
      LHU:     return {16'b0, sh[15:0]};
      default: return sh;
    endcase
  endfunction

  // head stays queued during the hazard wait, so younger stores cannot
  // enter the buffer ahead of it
  assign hazard_addr_o = ctrl_i.vaddr;
  assign take_exc  = (state_q == IDLE) && valid_i && ctrl_i.misaligned;
  assign take_load = (state_q == WAIT_HAZARD) && valid_i && !flush_i && !hazard_i;
  assign pop_o     = take_exc || take_load;

  // --------------------
  // state machine
  // --------------------
  always_comb begin
    state_d  = state_q;
    result_d = '0;
    unique case (state_q)
      IDLE: begin
        if (valid_i && !ctrl_i.misaligned) begin
          state_d = WAIT_HAZARD;
        end
        if (take_exc) begin
          result_d.valid    = 1'b1;
          result_d.trans_id = ctrl_i.trans_id;
          result_d.ex       = '{valid: 1'b1, cause: LD_ADDR_MISALIGNED, tval: ctrl_i.vaddr};
        end
      end
      WAIT_HAZARD: begin
        if (flush_i || !valid_i) begin
          state_d = IDLE;
        end else if (take_load) begin
          state_d = WAIT_GNT;
        end
      end
      // a granted request always completes, flush or not
      WAIT_GNT: begin
        if (mem_rsp_i.gnt) begin
          state_d = WAIT_DATA;
        end else if (flush_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        if (mem_rsp_i.rvalid) begin
          state_d           = IDLE;
          result_d.valid    = 1'b1;
          result_d.trans_id = ld_q.trans_id;
          result_d.result   = extract(ld_q.op, ld_q.vaddr[1:0], mem_rsp_i.rdata);
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      result_q <= '0;
    end else begin
      state_q  <= state_d;
      result_q <= result_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_load) begin
      ld_q <= ctrl_i;
    end
  end

  always_comb begin
    mem_req_o.req   = (state_q == WAIT_GNT);
    mem_req_o.we    = 1'b0;
    mem_req_o.addr  = {ld_q.vaddr[XLEN-1:2], 2'b00};
    mem_req_o.be    = ld_q.be;
    mem_req_o.wdata = '0;
  end

  assign result_o = result_q;

  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req && !mem_rsp_i.gnt && !flush_i |=> mem_req_o.req && $stable(mem_req_o))
    else $error("load request changed before grant");

endmodule

// File: hw/lsu_store_unit.sv
// Store unit. Buffers aligned stores as speculative until the core commits
// them, then drains committed entries oldest first on the store port.
`timescale 1ns/1ns

module lsu_store_unit #(
  parameter int unsigned STORE_BUF_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 valid_i,
  input  lsu_pkg::lsu_ctrl_t   ctrl_i,
  output logic                 pop_o,
  input  logic                 commit_i,
  output logic                 commit_ready_o,
  output logic                 no_st_pending_o,
  input  lsu_pkg::addr_t       hazard_addr_i,
  output logic                 hazard_o,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  lsu_pkg::mem_rsp_t    mem_rsp_i,
  output lsu_pkg::lsu_result_t result_o
);
  import lsu_pkg::*;

  localparam int unsigned PTR_W = $clog2(STORE_BUF_DEPTH);

  // one extra wrap bit to tell full from empty
  typedef logic [PTR_W:0]   ptr_t;
  typedef logic [PTR_W-1:0] idx_t;

  typedef struct packed {
    addr_t addr;
    be_t   be;
    data_t data;
  } st_entry_t;

  st_entry_t buf_q [STORE_BUF_DEPTH];
  ptr_t      rd_ptr_q, cm_ptr_q, wr_ptr_q;
  ptr_t      cm_ptr_d;
  ptr_t      used;
  logic      full;
  logic      push;
  logic      drain;

  // rd..cm is committed, cm..wr is speculative
  assign used            = wr_ptr_q - rd_ptr_q;
  assign full            = (used == ptr_t'(STORE_BUF_DEPTH));
  assign commit_ready_o  = (wr_ptr_q != cm_ptr_q);
  assign no_st_pending_o = (wr_ptr_q == rd_ptr_q);

  assign pop_o = valid_i && (ctrl_i.misaligned || !full);
  assign push  = pop_o && !ctrl_i.misaligned;
  assign drain = mem_req_o.req && mem_rsp_i.gnt;

  assign cm_ptr_d = cm_ptr_q + ptr_t'(commit_i && commit_ready_o);

  // --------------------
  // result
  // --------------------
  always_comb begin
    result_o          = '0;
    result_o.valid    = pop_o;
    result_o.trans_id = ctrl_i.trans_id;
    if (ctrl_i.misaligned) begin
      result_o.ex = '{valid: 1'b1, cause: ST_ADDR_MISALIGNED, tval: ctrl_i.vaddr};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      cm_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_q + ptr_t'(drain);
      cm_ptr_q <= cm_ptr_d;
      // flush drops everything younger than the last commit
      if (flush_i) begin
        wr_ptr_q <= cm_ptr_d;
      end else begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(push);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q[PTR_W-1:0]] <= '{
        addr: {ctrl_i.vaddr[XLEN-1:2], 2'b00},
        be:   ctrl_i.be,
        data: ctrl_i.wdata
      };
    end
  end

  // oldest committed entry goes out first
  always_comb begin
    mem_req_o.req   = (rd_ptr_q != cm_ptr_q);
    mem_req_o.we    = 1'b1;
    mem_req_o.addr  = buf_q[rd_ptr_q[PTR_W-1:0]].addr;
    mem_req_o.be    = buf_q[rd_ptr_q[PTR_W-1:0]].be;
    mem_req_o.wdata = buf_q[rd_ptr_q[PTR_W-1:0]].data;
  end

  // word match against every occupied entry, committed or not
  always_comb begin : hazard_check
    idx_t idx;
    hazard_o = 1'b0;
    for (int k = 0; k < STORE_BUF_DEPTH; k++) begin
      idx = rd_ptr_q[PTR_W-1:0] + k[PTR_W-1:0];
      if (k < int'(used) && buf_q[idx].addr[XLEN-1:2] == hazard_addr_i[XLEN-1:2]) begin
        hazard_o = 1'b1;
      end
    end
  end

  commit_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> commit_ready_o)
    else $error("commit with no speculative store buffered");

endmodule

// File: hw/lsu_result_pipe.sv
// Writeback delay line for result records, DEPTH cycles long.
`timescale 1ns/1ns

module lsu_result_pipe #(
  parameter int unsigned DEPTH = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_result_t d_i,
  output lsu_pkg::lsu_result_t d_o
);
  import lsu_pkg::*;

  if (DEPTH == 0) begin : gen_bypass
    assign d_o = d_i;
  end else begin : gen_regs
    lsu_result_t stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int unsigned i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        for (int unsigned i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

// File: hw/lsu_top.sv
// Load/store unit top level. Connects the AGU, issue queue, load and store
// units and the result pipelines; the core and two memory ports attach here.
`timescale 1ns/1ns

module lsu_top #(
  parameter int unsigned LOAD_PIPE_REGS  = 1,
  parameter int unsigned STORE_PIPE_REGS = 0,
  parameter int unsigned STORE_BUF_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 lsu_valid_i,
  input  lsu_pkg::lsu_req_t    lsu_req_i,
  output logic                 lsu_ready_o,
  output lsu_pkg::lsu_result_t load_result_o,
  output lsu_pkg::lsu_result_t store_result_o,
  input  logic                 commit_i,
  output logic                 commit_ready_o,
  output logic                 no_st_pending_o,
  output lsu_pkg::mem_req_t    ld_mem_req_o,
  input  lsu_pkg::mem_rsp_t    ld_mem_rsp_i,
  output lsu_pkg::mem_req_t    st_mem_req_o,
  input  lsu_pkg::mem_rsp_t    st_mem_rsp_i
);
  import lsu_pkg::*;

  lsu_ctrl_t   agu_ctrl;
  lsu_ctrl_t   head;
  logic        ld_valid;
  logic        st_valid;
  logic        pop_ld;
  logic        pop_st;
  addr_t       ld_hazard_addr;
  logic        st_hazard;
  lsu_result_t ld_result;
  lsu_result_t st_result;

  lsu_agu i_agu (
    .req_i  (lsu_req_i),
    .ctrl_o (agu_ctrl)
  );

  lsu_issue_ctrl i_issue_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .valid_i    (lsu_valid_i),
    .ctrl_i     (agu_ctrl),
    .ready_o    (lsu_ready_o),
    .pop_ld_i   (pop_ld),
    .pop_st_i   (pop_st),
    .head_o     (head),
    .ld_valid_o (ld_valid),
    .st_valid_o (st_valid)
  );

  // --------------------
  // load and store units
  // --------------------
  lsu_load_unit i_load_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (ld_valid),
    .ctrl_i        (head),
    .pop_o         (pop_ld),
    .hazard_addr_o (ld_hazard_addr),
    .hazard_i      (st_hazard),
    .mem_req_o     (ld_mem_req_o),
    .mem_rsp_i     (ld_mem_rsp_i),
    .result_o      (ld_result)
  );

  lsu_store_unit #(
    .STORE_BUF_DEPTH (STORE_BUF_DEPTH)
  ) i_store_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .valid_i         (st_valid),
    .ctrl_i          (head),
    .pop_o           (pop_st),
    .commit_i        (commit_i),
    .commit_ready_o  (commit_ready_o),
    .no_st_pending_o (no_st_pending_o),
    .hazard_addr_i   (ld_hazard_addr),
    .hazard_o        (st_hazard),
    .mem_req_o       (st_mem_req_o),
    .mem_rsp_i       (st_mem_rsp_i),
    .result_o        (st_result)
  );

  // writeback delay, trades latency for cycle time
  lsu_result_pipe #(
    .DEPTH (LOAD_PIPE_REGS)
  ) i_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_result_o)
  );

  lsu_result_pipe #(
    .DEPTH (STORE_PIPE_REGS)
  ) i_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_result_o)
  );

endmodule

// File: dv/lsu_tb.sv
// Testbench for lsu_top. Directed and random loads/stores run against a memory
// model on both ports, with a scoreboard keyed by trans_id and a shadow memory.
`timescale 1ns/1ns

module lsu_tb;
  import lsu_pkg::*;

  localparam int          MEM_WORDS  = 256;
  localparam int          NUM_TAGS   = 2**TRANS_ID_BITS;
  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] SEED       = 32'ha8f1_9b48;

  // what the scoreboard expects back for one trans_id
  typedef struct packed {
    logic       busy;
    logic       is_store;
    logic       exc;
    exc_cause_e cause;
    addr_t      tval;
    data_t      data;
    addr_t      waddr;
    be_t        be;
    data_t      wdata;
  } expect_t;

  typedef struct packed {
    addr_t addr;
    be_t   be;
    data_t data;
  } write_t;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        lsu_valid;
  lsu_req_t    lsu_req;
  logic        lsu_ready;
  lsu_result_t load_result;
  lsu_result_t store_result;
  logic        commit;
  logic        commit_ready;
  logic        no_st_pending;
  mem_req_t    ld_req;
  mem_rsp_t    ld_rsp;
  mem_req_t    st_req;
  mem_rsp_t    st_rsp;

  data_t       mem [MEM_WORDS];
  data_t       shadow [MEM_WORDS];
  expect_t     sb [NUM_TAGS];
  write_t      spec_q [$];
  write_t      commit_q [$];
  trans_id_t   next_tag;
  int          outstanding;
  int          commit_budget;
  logic        auto_commit;
  logic        abort;
  int          errors;
  int          timeouts;
  int          results;
  int          writes;
  logic [31:0] stim_state;
  logic [31:0] resp_state;

  lsu_top uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .flush_i         (flush),
    .lsu_valid_i     (lsu_valid),
    .lsu_req_i       (lsu_req),
    .lsu_ready_o     (lsu_ready),
    .load_result_o   (load_result),
    .store_result_o  (store_result),
    .commit_i        (commit),
    .commit_ready_o  (commit_ready),
    .no_st_pending_o (no_st_pending),
    .ld_mem_req_o    (ld_req),
    .ld_mem_rsp_i    (ld_rsp),
    .st_mem_req_o    (st_req),
    .st_mem_rsp_i    (st_rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic logic [31:0] resp_rand();
    resp_state = xorshift32(resp_state);
    return resp_state;
  endfunction

  // initial memory contents, a function of the full word address
  function automatic data_t fill_word(input addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h5A3C_96E1;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input be_t be, input data_t d);
    data_t m;
    m = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        m[i*8 +: 8] = d[i*8 +: 8];
      end
    end
    return m;
  endfunction

  function automatic data_t lane_mask(input be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // sign or zero extension of the addressed byte or half
  function automatic data_t load_value(input lsu_op_e op, input data_t word,
                                       input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[off*8 +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'h0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'h0, h};
      default: return word;
    endcase
  endfunction

  // a naturally aligned offset for the access size
  function automatic logic [1:0] pick_offset(input lsu_op_e op);
    logic [31:0] r;
    r = stim_rand();
    case (op)
      LB, LBU, SB: return r[1:0];
      LH, LHU, SH: return {r[0], 1'b0};
      default:     return 2'b00;
    endcase
  endfunction

  task automatic value_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    abort = 1'b1;
    $display("Timeout at %0t: gave up waiting for %s", $time, what);
  endtask

  task automatic issue_op(input lsu_op_e op, input addr_t ea, input data_t wdata);
    imm_t       imm;
    logic [1:0] off;
    logic       is_half;
    logic       is_word;
    expect_t    e;
    int         guard;
    imm     = imm_t'((stim_rand() % 128) - 64);
    off     = ea[1:0];
    is_half = op inside {LH, LHU, SH};
    is_word = op inside {LW, SW};
    e            = '0;
    e.busy       = 1'b1;
    e.is_store   = op inside {SB, SH, SW};
    e.exc        = (is_half && off[0]) || (is_word && off != 2'b00);
    e.cause      = e.is_store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    e.tval       = ea;
    e.waddr      = {ea[31:2], 2'b00};
    e.be         = (is_word ? 4'hF : (is_half ? 4'h3 : 4'h1)) << off;
    e.wdata      = wdata << (8 * off);
    if (!e.is_store && !e.exc) begin
      e.data = load_value(op, shadow[ea[9:2]], off);
    end
    guard = 0;
    while (!abort && (!lsu_ready || sb[next_tag].busy)) begin
      @(posedge clk);
      #1;
      guard++;
      if (guard > WAIT_LIMIT) begin
        report_timeout("a free trans_id and lsu_ready_o");
      end
    end
    if (!abort) begin
      sb[next_tag]      = e;
      outstanding++;
      lsu_req.op        = op;
      lsu_req.operand_a = ea - {{20{imm[11]}}, imm};
      lsu_req.imm       = imm;
      lsu_req.operand_b = wdata;
      lsu_req.trans_id  = next_tag;
      lsu_valid         = 1'b1;
      next_tag          = next_tag + 1'b1;
      @(posedge clk);
      #1;
      lsu_valid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int guard;
    guard = 0;
    while (!abort && outstanding != 0) begin
      @(posedge clk);
      #1;
      guard++;
      if (guard > WAIT_LIMIT) begin
        report_timeout("results of outstanding operations");
      end
    end
  endtask

  task automatic wait_drained();
    int guard;
    guard = 0;
    while (!abort && !no_st_pending) begin
      @(posedge clk);
      #1;
      guard++;
      if (guard > WAIT_LIMIT) begin
        report_timeout("the store buffer to drain");
      end
    end
  endtask

  task automatic commit_stores(input int n);
    int guard;
    guard = 0;
    commit_budget = n;
    while (!abort && commit_budget != 0) begin
      @(posedge clk);
      #1;
      guard++;
      if (guard > WAIT_LIMIT) begin
        report_timeout("commit_ready_o");
      end
    end
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  task automatic check_result(input lsu_result_t res, input logic from_store);
    expect_t e;
    e = sb[res.trans_id];
    results++;
    assert (e.busy && e.is_store == from_store)
      else note_failure($sformatf("result for trans_id %0d that was not outstanding",
                                  res.trans_id));
    if (e.busy && e.is_store == from_store) begin
      assert (res.ex.valid == e.exc)
        else value_mismatch($sformatf("trans_id %0d exception %b, expected %b",
                                      res.trans_id, res.ex.valid, e.exc));
      if (e.exc) begin
        assert (res.ex.cause == e.cause && res.ex.tval == e.tval)
          else value_mismatch($sformatf("trans_id %0d cause %0d tval %h, expected %0d %h",
                                        res.trans_id, res.ex.cause, res.ex.tval,
                                        e.cause, e.tval));
      end else begin
        assert (res.result == e.data)
          else value_mismatch($sformatf("trans_id %0d result %h, expected %h",
                                        res.trans_id, res.result, e.data));
      end
      if (from_store && !e.exc) begin
        spec_q.push_back('{addr: e.waddr, be: e.be, data: e.wdata});
      end
      sb[res.trans_id].busy = 1'b0;
      outstanding--;
    end
  endtask

  // --------------------
  // memory model and commit driver
  // --------------------
  initial begin : port_model
    int          ld_wait;
    int          st_wait;
    int          rd_wait;
    logic        ld_armed;
    logic        st_armed;
    logic        rd_pending;
    data_t       rd_word;
    logic [31:0] coin;
    ld_rsp     = '0;
    st_rsp     = '0;
    commit     = 1'b0;
    ld_armed   = 1'b0;
    st_armed   = 1'b0;
    rd_pending = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      ld_rsp = '0;
      st_rsp = '0;
      commit = 1'b0;
      if (!rst_n) begin
        ld_armed   = 1'b0;
        st_armed   = 1'b0;
        rd_pending = 1'b0;
      end else begin
        // read data comes one to four cycles after the grant
        if (rd_pending) begin
          if (rd_wait == 0) begin
            ld_rsp.rvalid = 1'b1;
            ld_rsp.rdata  = rd_word;
            rd_pending    = 1'b0;
          end else begin
            rd_wait--;
          end
        end
        if (ld_req.req) begin
          if (!ld_armed) begin
            ld_wait  = int'(resp_rand() % 4);
            ld_armed = 1'b1;
          end
          if (ld_wait == 0) begin
            ld_rsp.gnt = 1'b1;
            ld_armed   = 1'b0;
            rd_word    = mem[ld_req.addr[9:2]];
            rd_wait    = int'(resp_rand() % 4);
            rd_pending = 1'b1;
          end else begin
            ld_wait--;
          end
        end else begin
          ld_armed = 1'b0;
        end
        if (st_req.req) begin
          if (!st_armed) begin
            st_wait  = int'(resp_rand() % 4);
            st_armed = 1'b1;
          end
          if (st_wait == 0) begin
            st_rsp.gnt = 1'b1;
            st_armed   = 1'b0;
          end else begin
            st_wait--;
          end
        end else begin
          st_armed = 1'b0;
        end
        coin = resp_rand();
        if (commit_ready && (auto_commit ? coin[0] : commit_budget > 0)) begin
          commit = 1'b1;
          if (!auto_commit) begin
            commit_budget--;
          end
        end
      end
    end
  end

  // --------------------
  // monitor and scoreboard
  // --------------------
  always @(posedge clk) begin : monitor
    write_t w;
    logic   found;
    if (rst_n) begin
      if (st_req.req && st_rsp.gnt) begin
        if (commit_q.size() == 0) begin
          note_failure($sformatf("store port wrote %h with no commit pending", st_req.addr));
        end else begin
          w = commit_q.pop_front();
          writes++;
          assert (st_req.we && st_req.addr == w.addr && st_req.be == w.be &&
                  (st_req.wdata & lane_mask(w.be)) == (w.data & lane_mask(w.be)))
            else value_mismatch($sformatf("store write %h/%h/%h, expected %h/%h/%h",
                                          st_req.addr, st_req.be, st_req.wdata,
                                          w.addr, w.be, w.data));
          mem[st_req.addr[9:2]] = merge_bytes(mem[st_req.addr[9:2]], st_req.be, st_req.wdata);
        end
      end
      if (ld_req.req && ld_rsp.gnt) begin
        found = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
          if (sb[i].busy && !sb[i].is_store && !sb[i].exc && sb[i].waddr == ld_req.addr &&
              sb[i].be == ld_req.be) begin
            found = 1'b1;
          end
        end
        assert (found && !ld_req.we)
          else note_failure($sformatf("load port read %h/%h for no outstanding aligned load",
                                      ld_req.addr, ld_req.be));
      end
      // commits take the oldest store already reported
      if (commit && commit_ready) begin
        if (spec_q.size() == 0) begin
          note_failure("commit accepted with no speculative store reported");
        end else begin
          w = spec_q.pop_front();
          commit_q.push_back(w);
          shadow[w.addr[9:2]] = merge_bytes(shadow[w.addr[9:2]], w.be, w.data);
        end
      end
      if (flush) begin
        spec_q.delete();
      end
      if (load_result.valid) begin
        check_result(load_result, 1'b0);
      end
      if (store_result.valid) begin
        check_result(store_result, 1'b1);
      end
    end
  end

  ready_drop_a : assert property (@(posedge clk) disable iff (!rst_n)
    !lsu_ready |-> outstanding != 0)
    else note_failure("lsu_ready_o dropped with no operation outstanding");

  drained_idle_a : assert property (@(posedge clk) disable iff (!rst_n)
    no_st_pending |-> !st_req.req)
    else note_failure("store port requested with an empty store buffer");

  // --------------------
  // stimulus
  // --------------------
  initial begin : main_seq
    lsu_op_e     op;
    addr_t       ea;
    addr_t       flushed_ea;
    logic [31:0] r;
    rst_n         = 1'b0;
    flush         = 1'b0;
    lsu_valid     = 1'b0;
    lsu_req       = '0;
    next_tag      = '0;
    outstanding   = 0;
    commit_budget = 0;
    auto_commit   = 1'b0;
    abort         = 1'b0;
    errors        = 0;
    timeouts      = 0;
    results       = 0;
    writes        = 0;
    stim_state    = SEED;
    // response delays run on their own stream
    resp_state    = ~SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fill_word(addr_t'(i * 4));
      shadow[i] = fill_word(addr_t'(i * 4));
    end
    for (int i = 0; i < NUM_TAGS; i++) begin
      sb[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (lsu_ready && no_st_pending && !commit_ready && !ld_req.req && !st_req.req &&
            !load_result.valid && !store_result.valid)
      else note_failure("outputs not idle after reset");

    // store, commit, then read back through the hazard stall
    for (int k = 0; k < 16; k++) begin
      r       = stim_rand();
      op      = lsu_op_e'(5 + r % 3);
      ea      = addr_t'({r[13:8], 2'b00});
      ea[1:0] = pick_offset(op);
      issue_op(op, ea, stim_rand());
      wait_idle();
      commit_stores(1);
      op      = lsu_op_e'(stim_rand() % 5);
      ea[1:0] = pick_offset(op);
      issue_op(op, ea, '0);
      wait_idle();
    end

    // misaligned halves and words
    issue_op(LH, 32'h0000_02FF, '0);
    issue_op(LHU, 32'h0000_00F3, '0);
    issue_op(SH, 32'h0000_0201, 32'h1234_5678);
    issue_op(LW, 32'h0000_0206, '0);
    issue_op(SW, 32'h0000_020B, 32'hCAFE_F00D);
    issue_op(LW, 32'h0000_00A1, '0);
    wait_idle();

    // one committed store survives the flush, the younger two do not
    flushed_ea = '0;
    for (int k = 0; k < 3; k++) begin
      r          = stim_rand();
      op         = lsu_op_e'(5 + r % 3);
      ea         = addr_t'({r[13:8], 2'b00});
      ea[1:0]    = pick_offset(op);
      flushed_ea = ea;
      issue_op(op, ea, stim_rand());
    end
    wait_idle();
    commit_stores(1);
    pulse_flush();
    wait_drained();
    assert (!commit_ready)
      else note_failure("speculative stores left after flush");
    issue_op(LW, {flushed_ea[31:2], 2'b00}, '0);
    wait_idle();

    // back-to-back random mix, loads and stores in separate regions
    auto_commit = 1'b1;
    for (int k = 0; k < 80; k++) begin
      r  = stim_rand();
      op = lsu_op_e'(r % 8);
      if (op inside {SB, SH, SW}) begin
        ea = 32'h0000_0200 + {r[13:8], 2'b00} + r[17:16];
      end else begin
        ea = 32'h0000_0100 + {r[13:8], 2'b00} + r[17:16];
      end
      issue_op(op, ea, stim_rand());
    end
    wait_idle();
    wait_drained();
    auto_commit = 1'b0;

    assert (commit_q.size() == 0 && spec_q.size() == 0 && outstanding == 0)
      else note_failure("operations or stores left over at the end of the run");

    $display("results=%0d writes=%0d errors=%0d timeouts=%0d",
             results, writes, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: lsu_top.f
hw/lsu_pkg.sv
hw/lsu_agu.sv
hw/lsu_issue_ctrl.sv
hw/lsu_load_unit.sv
hw/lsu_store_unit.sv
hw/lsu_result_pipe.sv
hw/lsu_top.sv
dv/lsu_tb.sv
